// File: video_gen.f
src/xv_regs_pkg.sv
src/xv_video_pkg.sv
src/video_timing.sv
src/vgen_regs.sv
src/pf_fetch_fsm.sv
src/pf_pixel_shift.sv
src/video_gen.sv
dv/video_gen_chk.sv
dv/video_gen_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= video_gen_tb
RTL_TOP   ?= video_gen
FILELIST  ?= video_gen.f
BUILD_DIR ?= obj_dir
RTL_SRCS  ?= src/xv_regs_pkg.sv src/xv_video_pkg.sv src/video_timing.sv \
             src/vgen_regs.sv src/pf_fetch_fsm.sv src/pf_pixel_shift.sv src/video_gen.sv

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/video_gen_tb.sv
// **************************************************
// testbench for the video generator
// clock, reset, video RAM model, stimulus, timeout
// **************************************************
`timescale 1ns/1ns

module video_gen_tb;
import xv_regs_pkg::*;
import xv_video_pkg::*;

localparam int H_VIS = 32, H_FP = 4, H_SY = 4, H_BP = 8;
localparam int V_VIS = 8, V_FP = 2, V_SY = 2, V_BP = 2;
localparam int FRAME_CYCLES = (H_VIS + H_FP + H_SY + H_BP) * (V_VIS + V_FP + V_SY + V_BP);
localparam int FRAMES_USED  = 5;                    // frame 0 plus one per later test
localparam int CYCLE_LIMIT  = (FRAMES_USED + 1) * FRAME_CYCLES;

logic    clk;
logic    reset_i;
logic    reg_wr_i;
xr_num_e reg_num_i;
word_t   reg_data_i;
word_t   reg_data_o;
logic    video_intr_o;
logic    vram_sel_o;
addr_t   vram_addr_o;
word_t   vram_data_i;
color_t  color_index_o;
logic    hsync_o, vsync_o, dv_de_o;

int          seed = 32'hed99_f99a;
int          cycles = 0;
int          tests_run = 0;
int          tests_failed = 0;
int unsigned fail_base = 0;

video_gen #(
    .H_VISIBLE(H_VIS), .H_FRONT(H_FP), .H_SYNC(H_SY), .H_BACK(H_BP),
    .V_VISIBLE(V_VIS), .V_FRONT(V_FP), .V_SYNC(V_SY), .V_BACK(V_BP)
) video_gen_inst (.*);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

// video RAM with one cycle read latency
always @(posedge clk) begin
    if (vram_sel_o) begin
        vram_data_i <= vram_addr_o ^ 16'ha5c3;
    end
end

always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end
end

task automatic write_reg(input xr_num_e num, input word_t data);
    @(posedge clk);
    reg_wr_i   <= 1'b1;
    reg_num_i  <= num;
    reg_data_i <= data;
    @(posedge clk);
    reg_wr_i   <= 1'b0;
endtask

task automatic read_reg(input xr_num_e num);
    @(posedge clk);
    reg_num_i <= num;
    repeat (2) @(posedge clk);                      // read data lands one cycle later
endtask

task automatic wait_frame_start;
    @(posedge vsync_o);
    @(posedge clk);
endtask

task automatic report_test(input string name);
    int unsigned fails;
    fails = video_gen_inst.chk_inst.fail_cnt - fail_base;
    fail_base = video_gen_inst.chk_inst.fail_cnt;
    tests_run++;
    if (fails != 0) begin
        tests_failed++;
    end
    $display("test %-16s done, %0d assertion failures", name, fails);
endtask

initial begin
    reset_i     = 1'b1;
    reg_wr_i    = 1'b0;
    reg_num_i   = XR_VID_CTRL;
    reg_data_i  = '0;
    vram_data_i = '0;
    repeat (8) @(posedge clk);
    reset_i <= 1'b0;

    // random values through the stored registers, then constants and holes
    write_reg(XR_PA_DISP_ADDR, word_t'($random(seed)));
    read_reg(XR_PA_DISP_ADDR);
    write_reg(XR_PA_LINE_LEN, word_t'($random(seed)));
    read_reg(XR_PA_LINE_LEN);
    write_reg(XR_VID_LEFT, word_t'($random(seed)));
    read_reg(XR_VID_LEFT);
    write_reg(XR_VID_RIGHT, word_t'($random(seed)));
    read_reg(XR_VID_RIGHT);
    read_reg(XR_VID_HSIZE);
    read_reg(XR_VID_VSIZE);
    read_reg(xr_num_e'(4'h1));
    read_reg(xr_num_e'(4'h7));
    read_reg(xr_num_e'(4'hF));
    report_test("reg_readback");

    wait_frame_start();
    report_test("timing");

    // full width playfield, no colorbase, set up in vertical blank
    write_reg(XR_PA_DISP_ADDR, 16'h0100);
    write_reg(XR_PA_LINE_LEN, 16'd16);
    write_reg(XR_VID_LEFT, 16'd0);
    write_reg(XR_VID_RIGHT, word_t'(H_VIS));
    write_reg(XR_PA_GFX_CTRL, 16'h0000);
    wait_frame_start();
    report_test("pixels");

    write_reg(XR_PA_GFX_CTRL, 16'h5a00);            // colorbase 5a
    write_reg(XR_VID_CTRL, word_t'($random(seed)) & 16'h00ff);
    write_reg(XR_VID_LEFT, 16'd4);
    write_reg(XR_VID_RIGHT, 16'd28);
    wait_frame_start();
    write_reg(XR_PA_GFX_CTRL, 16'h0080);            // blank on
    wait_frame_start();
    report_test("colorbase_border");

    write_reg(XR_VID_INTR, 16'h0001);
    wait_frame_start();
    report_test("interrupt");

    $display("tests run %0d, tests failed %0d, assertion failures %0d",
             tests_run, tests_failed, video_gen_inst.chk_inst.fail_cnt);
    if (tests_failed == 0 && video_gen_inst.chk_inst.fail_cnt == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

// File: dv/video_gen_chk.sv
// **************************************************
// bound assertions for the video generator
// timing, register read-back, pixels, interrupt
// **************************************************
`timescale 1ns/1ns

module video_gen_chk #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
)(
    input wire logic                 clk,
    input wire logic                 reset_i,
    input wire logic                 reg_wr_i,
    input wire xv_regs_pkg::xr_num_e reg_num_i,
    input wire xv_regs_pkg::word_t   reg_data_i,
    input wire xv_regs_pkg::word_t   reg_data_o,
    input wire logic                 video_intr_o,
    input wire logic                 vram_sel_o,
    input wire xv_video_pkg::color_t color_index_o,
    input wire logic                 hsync_o,
    input wire logic                 vsync_o,
    input wire logic                 dv_de_o
);
import xv_regs_pkg::*;

localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

int unsigned fail_cnt = 0;                          // read by the testbench
word_t       disp_addr, line_len, vid_left, vid_right;
logic [7:0]  border, colorbase;
logic        blank;
word_t       rd_exp, rd_exp_q, pix_word;
logic        rd_known, rd_known_q, force_q;
logic        hs_prev, vs_prev, de_prev, hs_seen;
int          hs_len, since_rise, de_cnt, x_cnt, line_cnt, intr_cd;
logic [7:0]  pix_exp;

// expected read data from the register map rules
always_comb begin
    rd_known = 1'b1;
    case (reg_num_i)
        XR_PA_DISP_ADDR: rd_exp = disp_addr;
        XR_PA_LINE_LEN:  rd_exp = line_len;
        XR_VID_LEFT:     rd_exp = vid_left;
        XR_VID_RIGHT:    rd_exp = vid_right;
        XR_VID_HSIZE:    rd_exp = word_t'(H_VISIBLE);
        XR_VID_VSIZE:    rd_exp = word_t'(V_VISIBLE);
        XR_VID_CTRL, XR_SCANLINE, XR_PA_GFX_CTRL: begin
            rd_exp   = '0;
            rd_known = 1'b0;                        // not compared
        end
        default:         rd_exp = '0;               // unused and write-only numbers
    endcase
end

// expected pixel from line n, pixel x and the memory fill rule
always_comb begin
    pix_word = word_t'(disp_addr + word_t'(line_cnt) * line_len + word_t'(x_cnt / 2)) ^ 16'ha5c3;
    pix_exp  = x_cnt[0] ? pix_word[7:0] : pix_word[15:8];
    if (!blank && (x_cnt >= int'(vid_left)) && (x_cnt < int'(vid_right))) begin
        pix_exp = pix_exp ^ colorbase;
    end else begin
        pix_exp = border;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        disp_addr <= '0;
        line_len  <= word_t'(H_VISIBLE / 2);
        vid_left  <= '0;
        vid_right <= word_t'(H_VISIBLE);
        border    <= BORDER_RESET;
        colorbase <= '0;
        blank     <= 1'b1;
        rd_known_q <= 1'b0;
        force_q   <= 1'b0;
        hs_prev   <= 1'b0;
        vs_prev   <= 1'b0;
        de_prev   <= 1'b0;
        hs_seen   <= 1'b0;
        hs_len    <= 0;
        since_rise <= 0;
        de_cnt    <= 0;
        x_cnt     <= 0;
        line_cnt  <= 0;
        intr_cd   <= 0;
    end else begin
        rd_exp_q   <= rd_exp;
        rd_known_q <= rd_known;
        force_q    <= reg_wr_i && (reg_num_i == XR_VID_INTR);
        if (reg_wr_i) begin
            case (reg_num_i)
                XR_VID_CTRL:     border <= reg_data_i[7:0];
                XR_VID_LEFT:     vid_left <= reg_data_i;
                XR_VID_RIGHT:    vid_right <= reg_data_i;
                XR_PA_DISP_ADDR: disp_addr <= reg_data_i;
                XR_PA_LINE_LEN:  line_len <= reg_data_i;
                XR_PA_GFX_CTRL: begin
                    colorbase <= reg_data_i[GFX_CB_LSB +: 8];
                    blank     <= reg_data_i[GFX_BLANK_BIT];
                end
                default: begin
                end
            endcase
        end
        hs_prev <= hsync_o;
        vs_prev <= vsync_o;
        de_prev <= dv_de_o;
        hs_len  <= hsync_o ? hs_len + 1 : 0;
        if (hsync_o && !hs_prev) begin
            since_rise <= 1;
            hs_seen    <= 1'b1;
        end else begin
            since_rise <= since_rise + 1;
        end
        x_cnt <= dv_de_o ? x_cnt + 1 : 0;
        if (vsync_o && !vs_prev) begin              // new frame
            de_cnt   <= 0;
            line_cnt <= 0;
        end else begin
            de_cnt <= dv_de_o ? de_cnt + 1 : de_cnt;
            if (!dv_de_o && de_prev) begin
                line_cnt <= line_cnt + 1;
            end
        end
        if (!dv_de_o && de_prev && (line_cnt == V_VISIBLE - 1)) begin
            intr_cd <= H_TOTAL - H_VISIBLE - 1;     // pulse due at the start of the next line
        end else if (intr_cd != 0) begin
            intr_cd <= intr_cd - 1;
        end
    end
end

a_hsync_width: assert property (@(posedge clk) disable iff (reset_i)
    (!hsync_o && hs_prev) |-> (hs_len == H_SYNC))
    else begin
        $error("FAILED hsync_o width got %h expected %h", hs_len, H_SYNC);
        fail_cnt++;
    end

a_line_total: assert property (@(posedge clk) disable iff (reset_i)
    (hsync_o && !hs_prev && hs_seen) |-> (since_rise == H_TOTAL))
    else begin
        $error("FAILED hsync_o period got %h expected %h", since_rise, H_TOTAL);
        fail_cnt++;
    end

a_de_count: assert property (@(posedge clk) disable iff (reset_i)
    (vsync_o && !vs_prev) |-> (de_cnt == V_VISIBLE * H_VISIBLE))
    else begin
        $error("FAILED dv_de_o count got %h expected %h", de_cnt, V_VISIBLE * H_VISIBLE);
        fail_cnt++;
    end

a_read_back: assert property (@(posedge clk) disable iff (reset_i)
    rd_known_q |-> (reg_data_o == rd_exp_q))
    else begin
        $error("FAILED reg_data_o got %h expected %h", reg_data_o, rd_exp_q);
        fail_cnt++;
    end

a_pixel: assert property (@(posedge clk) disable iff (reset_i)
    dv_de_o |-> (color_index_o == pix_exp))
    else begin
        $error("FAILED color_index_o got %h expected %h", color_index_o, pix_exp);
        fail_cnt++;
    end

a_blank_idle: assert property (@(posedge clk) disable iff (reset_i)
    blank |-> !vram_sel_o)
    else begin
        $error("video RAM was read while the playfield was blanked");
        fail_cnt++;
    end

a_intr: assert property (@(posedge clk) disable iff (reset_i)
    video_intr_o == ((intr_cd == 1) || force_q))
    else begin
        $error("FAILED video_intr_o got %h expected %h", video_intr_o,
               ((intr_cd == 1) || force_q));
        fail_cnt++;
    end

endmodule

bind video_gen video_gen_chk #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) chk_inst (
    .clk(clk), .reset_i(reset_i), .reg_wr_i(reg_wr_i), .reg_num_i(reg_num_i),
    .reg_data_i(reg_data_i), .reg_data_o(reg_data_o), .video_intr_o(video_intr_o),
    .vram_sel_o(vram_sel_o), .color_index_o(color_index_o), .hsync_o(hsync_o),
    .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

// File: src/video_gen.sv
// **************************************************
// video generator top level
// timing, registers, fetch FSM and pixel stage
// **************************************************
`timescale 1ns/1ns

module video_gen #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
)(
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  reg_wr_i,
    input  wire xv_regs_pkg::xr_num_e  reg_num_i,
    input  wire xv_regs_pkg::word_t    reg_data_i,
    output      xv_regs_pkg::word_t    reg_data_o,
    output      logic                  video_intr_o,
    output      logic                  vram_sel_o,
    output      xv_video_pkg::addr_t   vram_addr_o,
    input  wire xv_regs_pkg::word_t    vram_data_i,
    output      xv_video_pkg::color_t  color_index_o,
    output      logic                  hsync_o,
    output      logic                  vsync_o,
    output      logic                  dv_de_o
);
import xv_video_pkg::*;

hres_t   h_count;
vres_t   v_count;
logic    h_visible;
logic    v_visible;
sync_t   tim_sync;                                  // from the counters
sync_t   pix_sync;                                  // aligned with color_index_o
logic    end_of_line;
logic    end_of_frame;
logic    end_of_visible;
pf_cfg_t pf_cfg;
logic    word_load;

assign hsync_o = pix_sync.hsync;
assign vsync_o = pix_sync.vsync;
assign dv_de_o = pix_sync.dv_de;

video_timing #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) video_timing_inst (
    .clk(clk),
    .reset_i(reset_i),
    .h_count_o(h_count),
    .v_count_o(v_count),
    .h_visible_o(h_visible),
    .v_visible_o(v_visible),
    .sync_o(tim_sync),
    .end_of_line_o(end_of_line),
    .end_of_frame_o(end_of_frame),
    .end_of_visible_o(end_of_visible)
);

vgen_regs #(
    .H_VISIBLE(H_VISIBLE),
    .V_VISIBLE(V_VISIBLE)
) vgen_regs_inst (
    .clk(clk),
    .reset_i(reset_i),
    .reg_wr_i(reg_wr_i),
    .reg_num_i(reg_num_i),
    .reg_data_i(reg_data_i),
    .reg_data_o(reg_data_o),
    .v_count_i(v_count),
    .end_of_visible_i(end_of_visible),
    .cfg_o(pf_cfg),
    .video_intr_o(video_intr_o)
);

pf_fetch_fsm #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) pf_fetch_fsm_inst (
    .clk(clk),
    .reset_i(reset_i),
    .h_count_i(h_count),
    .v_visible_i(v_visible),
    .end_of_line_i(end_of_line),
    .end_of_frame_i(end_of_frame),
    .cfg_i(pf_cfg),
    .vram_sel_o(vram_sel_o),
    .vram_addr_o(vram_addr_o),
    .word_load_o(word_load)
);

pf_pixel_shift pf_pixel_shift_inst (
    .clk(clk),
    .reset_i(reset_i),
    .word_load_i(word_load),
    .vram_data_i(vram_data_i),
    .h_count_i(h_count),
    .h_visible_i(h_visible),
    .sync_i(tim_sync),
    .cfg_i(pf_cfg),
    .color_index_o(color_index_o),
    .sync_o(pix_sync)
);

endmodule

// File: src/pf_pixel_shift.sv
// **************************************************
// pixel output stage with two pixels per word,
// colorbase, border window and blank
// **************************************************
`timescale 1ns/1ns

module pf_pixel_shift (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  word_load_i,
    input  wire xv_regs_pkg::word_t    vram_data_i,
    input  wire xv_video_pkg::hres_t   h_count_i,
    input  wire logic                  h_visible_i,
    input  wire xv_video_pkg::sync_t   sync_i,
    input  wire xv_video_pkg::pf_cfg_t cfg_i,
    output      xv_video_pkg::color_t  color_index_o,
    output      xv_video_pkg::sync_t   sync_o           // delayed to match color_index_o
);
import xv_regs_pkg::*;
import xv_video_pkg::*;

word_t  next_word;                                  // word waiting for its pixel pair
word_t  cur_word;                                   // word shown at this count
color_t pix;
logic   in_window;

always_ff @(posedge clk) begin
    if (word_load_i) begin
        next_word <= vram_data_i;
    end
    if (h_count_i[0]) begin
        cur_word <= next_word;                      // counts 2k and 2k+1 share a word
    end
end

always_comb begin
    pix       = h_count_i[0] ? cur_word[7:0] : cur_word[15:8];    // high byte first
    in_window = h_visible_i && !cfg_i.blank &&
                (16'(h_count_i) >= cfg_i.vid_left) &&
                (16'(h_count_i) < cfg_i.vid_right);
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        sync_o        <= '0;
        color_index_o <= '0;
    end else begin
        sync_o <= sync_i;
        if (!sync_i.dv_de) begin
            color_index_o <= '0;
        end else if (in_window) begin
            color_index_o <= pix ^ cfg_i.colorbase;
        end else begin
            color_index_o <= cfg_i.border;          // border is never XORed
        end
    end
end

endmodule

// File: src/pf_fetch_fsm.sv
// **************************************************
// per-line fetch FSM for the bitmap playfield
// video RAM reads and line base address
// **************************************************
`timescale 1ns/1ns

module pf_fetch_fsm #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
)(
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire xv_video_pkg::hres_t   h_count_i,
    input  wire logic                  v_visible_i,
    input  wire logic                  end_of_line_i,
    input  wire logic                  end_of_frame_i,
    input  wire xv_video_pkg::pf_cfg_t cfg_i,
    output      logic                  vram_sel_o,
    output      xv_video_pkg::addr_t   vram_addr_o,
    output      logic                  word_load_o      // vram data valid this cycle
);
import xv_video_pkg::*;

localparam int    H_TOTAL    = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
localparam int    V_TOTAL    = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
localparam hres_t FETCH_GO   = hres_t'(H_TOTAL - 5);   // first select lands 4 cycles before pixel 0
localparam hres_t WORDS      = hres_t'(H_VISIBLE / 2);
localparam vres_t V_LAST     = vres_t'(V_TOTAL - 1);
localparam vres_t V_VIS_LAST = vres_t'(V_VISIBLE - 1);

fetch_state_e state;
hres_t        word_cnt;                             // words read on this line
vres_t        line_cnt;                             // follows the raster line
addr_t        line_base;                            // first word of the current line
logic         next_vis;

// the fetch runs one line ahead so it needs the visibility of the next line
always_comb begin
    next_vis = (line_cnt == V_LAST) || (v_visible_i && (line_cnt != V_VIS_LAST));
end

assign vram_sel_o = (state == FS_READ);

always_ff @(posedge clk) begin
    if (reset_i) begin
        state       <= FS_IDLE;
        line_cnt    <= '0;
        line_base   <= '0;
        word_load_o <= 1'b0;
    end else begin
        word_load_o <= vram_sel_o;                  // fixed one-cycle read latency
        if (end_of_frame_i) begin
            line_cnt  <= '0;
            line_base <= cfg_i.disp_addr;
        end else if (end_of_line_i) begin
            line_cnt <= vres_t'(line_cnt + 1'b1);
            if (v_visible_i) begin
                line_base <= addr_t'(line_base + cfg_i.line_len);
            end
        end

        case (state)
            FS_IDLE: begin
                if ((h_count_i == FETCH_GO) && next_vis && !cfg_i.blank) begin
                    state    <= FS_READ;
                    word_cnt <= '0;
                    // line 0 starts at disp_addr, later lines one line_len on
                    vram_addr_o <= (line_cnt == V_LAST) ? cfg_i.disp_addr :
                                   addr_t'(line_base + cfg_i.line_len);
                end
            end
            FS_READ: begin
                word_cnt    <= hres_t'(word_cnt + 1'b1);
                vram_addr_o <= addr_t'(vram_addr_o + 1'b1);
                state       <= FS_WAIT;
            end
            FS_WAIT: begin
                state <= (word_cnt == WORDS) ? FS_IDLE : FS_READ;
            end
            default: begin
                state <= FS_IDLE;
            end
        endcase
    end
end

endmodule

// File: src/vgen_regs.sv
// **************************************************
// register file with write decode and read-back
// vertical blank interrupt pulse
// **************************************************
`timescale 1ns/1ns

module vgen_regs #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
)(
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  reg_wr_i,        // write strobe
    input  wire xv_regs_pkg::xr_num_e  reg_num_i,
    input  wire xv_regs_pkg::word_t    reg_data_i,
    output      xv_regs_pkg::word_t    reg_data_o,      // valid one cycle after reg_num_i
    input  wire xv_video_pkg::vres_t   v_count_i,
    input  wire logic                  end_of_visible_i,
    output      xv_video_pkg::pf_cfg_t cfg_o,
    output      logic                  video_intr_o
);
import xv_regs_pkg::*;
import xv_video_pkg::*;

word_t rd_data;

always_ff @(posedge clk) begin
    if (reset_i) begin
        cfg_o.border    <= BORDER_RESET;
        cfg_o.colorbase <= COLORBASE_RESET;
        cfg_o.blank     <= BLANK_RESET;
        cfg_o.disp_addr <= DISP_ADDR_RESET;
        cfg_o.line_len  <= 16'(H_VISIBLE / 2);      // two pixels per word
        cfg_o.vid_left  <= LEFT_RESET;
        cfg_o.vid_right <= 16'(H_VISIBLE);          // window open over the full width
        video_intr_o    <= 1'b0;
    end else begin
        video_intr_o    <= end_of_visible_i;        // one pulse per frame
        if (reg_wr_i) begin
            case (reg_num_i)
                XR_VID_CTRL: begin
                    cfg_o.border <= reg_data_i[7:0];
                end
                XR_VID_INTR: begin
                    video_intr_o <= 1'b1;           // forced by software
                end
                XR_VID_LEFT: begin
                    cfg_o.vid_left <= reg_data_i;
                end
                XR_VID_RIGHT: begin
                    cfg_o.vid_right <= reg_data_i;
                end
                XR_PA_GFX_CTRL: begin
                    cfg_o.colorbase <= reg_data_i[GFX_CB_LSB +: 8];
                    cfg_o.blank     <= reg_data_i[GFX_BLANK_BIT];
                end
                XR_PA_DISP_ADDR: begin
                    cfg_o.disp_addr <= reg_data_i;
                end
                XR_PA_LINE_LEN: begin
                    cfg_o.line_len <= reg_data_i;
                end
                default: begin                      // read-only or unused
                end
            endcase
        end
    end
end

always_comb begin
    case (reg_num_i)
        XR_VID_CTRL:     rd_data = {8'h00, cfg_o.border};
        XR_VID_LEFT:     rd_data = cfg_o.vid_left;
        XR_VID_RIGHT:    rd_data = cfg_o.vid_right;
        XR_SCANLINE:     rd_data = word_t'(v_count_i);
        XR_VID_HSIZE:    rd_data = word_t'(H_VISIBLE);
        XR_VID_VSIZE:    rd_data = word_t'(V_VISIBLE);
        XR_PA_GFX_CTRL:  rd_data = {cfg_o.colorbase, cfg_o.blank, 7'h00};
        XR_PA_DISP_ADDR: rd_data = cfg_o.disp_addr;
        XR_PA_LINE_LEN:  rd_data = cfg_o.line_len;
        default:         rd_data = '0;              // XR_VID_INTR and unused numbers
    endcase
end

always_ff @(posedge clk) begin
    reg_data_o <= rd_data;
end

endmodule

// File: src/video_timing.sv
// **************************************************
// raster counters with registered sync, visibility
// and line, frame and end-of-visible strobes
// **************************************************
`timescale 1ns/1ns

module video_timing #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
)(
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    output      xv_video_pkg::hres_t   h_count_o,
    output      xv_video_pkg::vres_t   v_count_o,
    output      logic                  h_visible_o,
    output      logic                  v_visible_o,
    output      xv_video_pkg::sync_t   sync_o,
    output      logic                  end_of_line_o,
    output      logic                  end_of_frame_o,
    output      logic                  end_of_visible_o
);
import xv_video_pkg::*;

localparam hres_t H_VIS      = hres_t'(H_VISIBLE);
localparam hres_t HS_BEGIN   = hres_t'(H_VISIBLE + H_FRONT);
localparam hres_t HS_END     = hres_t'(H_VISIBLE + H_FRONT + H_SYNC);
localparam hres_t H_LAST     = hres_t'(H_VISIBLE + H_FRONT + H_SYNC + H_BACK - 1);
localparam vres_t V_VIS      = vres_t'(V_VISIBLE);
localparam vres_t VS_BEGIN   = vres_t'(V_VISIBLE + V_FRONT);
localparam vres_t VS_END     = vres_t'(V_VISIBLE + V_FRONT + V_SYNC);
localparam vres_t V_LAST     = vres_t'(V_VISIBLE + V_FRONT + V_SYNC + V_BACK - 1);
localparam vres_t V_VIS_LAST = vres_t'(V_VISIBLE - 1);

hres_t h_next;
vres_t v_next;
logic  h_vis_next;
logic  v_vis_next;

// next counts, decoded before the register so flags line up with the count
always_comb begin
    h_next = (h_count_o == H_LAST) ? '0 : hres_t'(h_count_o + 1'b1);
    v_next = v_count_o;
    if (h_count_o == H_LAST) begin
        v_next = (v_count_o == V_LAST) ? '0 : vres_t'(v_count_o + 1'b1);
    end
    h_vis_next = (h_next < H_VIS);
    v_vis_next = (v_next < V_VIS);
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count_o        <= H_LAST;                 // parked on the last count of a frame
        v_count_o        <= V_LAST;
        h_visible_o      <= 1'b0;
        v_visible_o      <= 1'b0;
        sync_o           <= '0;
        end_of_line_o    <= 1'b1;                   // matches the parked position
        end_of_frame_o   <= 1'b1;
        end_of_visible_o <= 1'b0;
    end else begin
        h_count_o        <= h_next;
        v_count_o        <= v_next;
        h_visible_o      <= h_vis_next;
        v_visible_o      <= v_vis_next;
        sync_o.hsync     <= (h_next >= HS_BEGIN) && (h_next < HS_END);
        sync_o.vsync     <= (v_next >= VS_BEGIN) && (v_next < VS_END);
        sync_o.dv_de     <= h_vis_next && v_vis_next;
        end_of_line_o    <= (h_next == H_LAST);
        end_of_frame_o   <= (h_next == H_LAST) && (v_next == V_LAST);
        end_of_visible_o <= (h_next == H_LAST) && (v_next == V_VIS_LAST);
    end
end

endmodule

// File: src/xv_video_pkg.sv
// **************************************************
// pixel, address and raster count types
// sync and playfield configuration structs
// fetch FSM states
// **************************************************
package xv_video_pkg;

typedef logic [7:0]  color_t;                       // colour index into the palette
typedef logic [15:0] addr_t;                        // video RAM word address
typedef logic [9:0]  hres_t;                        // horizontal count
typedef logic [9:0]  vres_t;                        // vertical count

typedef struct packed {
    logic hsync;
    logic vsync;
    logic dv_de;                                    // display enable
} sync_t;

typedef struct packed {
    color_t      border;                            // shown outside the window
    color_t      colorbase;                         // XORed into every playfield pixel
    logic        blank;
    addr_t       disp_addr;                         // start of line 0
    logic [15:0] line_len;                          // words per line
    logic [15:0] vid_left;                          // window start, inclusive
    logic [15:0] vid_right;                         // window end, exclusive
} pf_cfg_t;

typedef enum logic [1:0] {
    FS_IDLE = 2'b00,                                // waiting for the next line
    FS_READ = 2'b01,                                // select high for one word
    FS_WAIT = 2'b10                                 // gap cycle between reads
} fetch_state_e;

endpackage

// File: src/xv_regs_pkg.sv
// **************************************************
// register map of the video generator
// register numbers, field positions, reset values
// **************************************************
package xv_regs_pkg;

typedef logic [15:0] word_t;                        // register or video RAM word

typedef enum logic [3:0] {
    XR_VID_CTRL     = 4'h0,                         // border color in [7:0]
    XR_VID_INTR     = 4'h3,                         // any write raises the video interrupt
    XR_VID_LEFT     = 4'h4,                         // first pixel inside the window
    XR_VID_RIGHT    = 4'h5,                         // first pixel past the window
    XR_SCANLINE     = 4'h8,                         // current raster line, read only
    XR_VID_HSIZE    = 4'hA,                         // visible width, read only
    XR_VID_VSIZE    = 4'hB,                         // visible height, read only
    XR_PA_GFX_CTRL  = 4'hC,                         // colorbase and blank
    XR_PA_DISP_ADDR = 4'hD,                         // word address of line 0
    XR_PA_LINE_LEN  = 4'hE                          // words added per line
} xr_num_e;

// XR_PA_GFX_CTRL layout
localparam int GFX_CB_LSB    = 8;                   // colorbase in [15:8]
localparam int GFX_BLANK_BIT = 7;                   // 1 turns the playfield off

// values loaded by reset
localparam logic [7:0] BORDER_RESET    = 8'h08;     // dark grey, shows the core is alive
localparam logic [7:0] COLORBASE_RESET = 8'h00;
localparam logic       BLANK_RESET     = 1'b1;      // playfield off until software enables it
localparam word_t      DISP_ADDR_RESET = 16'h0000;
localparam word_t      LEFT_RESET      = 16'h0000;

endpackage
